// ==== rtl/const_pack.sv ====
package const_pack;

    // ------------------------------------------------------------------------
    // Sample and lane geometry
    // ------------------------------------------------------------------------

    localparam int Nadc = 8;  // Signed ADC sample width.
    localparam int Nti  = 4;  // Samples delivered per word.
    localparam int Nout = 2;  // Phase interpolator outputs.
    localparam int Npi  = 6;  // Interpolator control code width.

    // ------------------------------------------------------------------------
    // Loop arithmetic widths
    // ------------------------------------------------------------------------

    // Two extra bits cover the detector sum over a word.
    localparam int Nerr = Nadc + 2;

    // Fractional bits kept below the integer part of both accumulators.
    localparam int phase_est_shift = 8;

    localparam int Nacc = Nerr + phase_est_shift + 1;

endpackage

// ==== rtl/cdr_pack.sv ====
package cdr_pack;

    // ------------------------------------------------------------------------
    // Loop control
    // ------------------------------------------------------------------------

    // Kp and Ki are left shift amounts applied to the phase error.
    localparam int gain_width = 3;

    // The loop ignores the detector for this many clocks after reset.
    localparam int reset_hold_cycles = 32;
    localparam int hold_cnt_width    = $clog2(reset_hold_cycles + 1);

    // ------------------------------------------------------------------------
    // Snapshot sequencer
    // ------------------------------------------------------------------------

    typedef enum logic [1:0] {
        WAIT   = 2'd0,  // Waiting for the request to drop.
        READY  = 2'd1,  // Armed for the next rising request.
        SAMPLE = 2'd2
    } snap_state_t;

endpackage

// ==== rtl/cdr_debug_intf.sv ====
`timescale 1ns/1ps

// Static debug configuration shared by the detector and the loop filter.
interface cdr_debug_intf;

    logic signed [const_pack::Nerr-1:0] pd_offset;     // Added to every detector output.
    logic        [cdr_pack::gain_width-1:0] Kp;
    logic        [cdr_pack::gain_width-1:0] Ki;
    logic                               en_freq_est;
    logic                               en_ext_pi_ctl;
    logic        [const_pack::Npi-1:0]  ext_pi_ctl;    // Manual interpolator code.

    // The detector only needs its offset.
    modport pd (
        input pd_offset
    );

    // Gains, integral enable and the manual code override.
    modport loop (
        input Kp,
        input Ki,
        input en_freq_est,
        input en_ext_pi_ctl,
        input ext_pi_ctl
    );

endinterface

// ==== rtl/mm_pd.sv ====
`timescale 1ns/1ps

module mm_pd (
    input  logic                               clk,
    input  logic                               ext_rstb,
    input  logic signed [const_pack::Nadc-1:0] din_i [const_pack::Nti-1:0],
    input  logic                               din_valid_i,
    cdr_debug_intf.pd                          dbg_i,
    output logic signed [const_pack::Nerr-1:0] err_o,
    output logic                               err_valid_o
);

    logic signed [const_pack::Nadc-1:0] last_q;                  // Final sample of the last word.
    logic signed [const_pack::Nadc-1:0] x_ext [const_pack::Nti:0];
    logic signed [const_pack::Nerr+3:0] pd_sum;
    logic signed [const_pack::Nerr+3:0] pd_total;
    logic signed [const_pack::Nerr-1:0] err_sat;

    // Entry 0 holds x[-1], so every lane sees its predecessor at index k.
    always_comb begin
        x_ext[0] = last_q;
        for (int k = 0; k < const_pack::Nti; k++) begin
            x_ext[k+1] = din_i[k];
        end
    end

    // ------------------------------------------------------------------------
    // Mueller-Muller sum across lane boundaries
    // ------------------------------------------------------------------------

    always_comb begin : pd_sum_calc
        logic signed [const_pack::Nerr+3:0] cur;
        logic signed [const_pack::Nerr+3:0] prv;
        pd_sum = '0;
        for (int k = 1; k <= const_pack::Nti; k++) begin
            cur    = x_ext[k];
            prv    = x_ext[k-1];
            pd_sum = pd_sum + ((prv >= 0) ? cur : -cur) - ((cur >= 0) ? prv : -prv);
        end
    end

    assign pd_total = pd_sum + dbg_i.pd_offset;

    // Clamp to the Nerr-bit signed range.
    always_comb begin
        if (pd_total > (2 ** (const_pack::Nerr - 1) - 1)) begin
            err_sat = {1'b0, {(const_pack::Nerr - 1){1'b1}}};
        end else if (pd_total < -(2 ** (const_pack::Nerr - 1))) begin
            err_sat = {1'b1, {(const_pack::Nerr - 1){1'b0}}};
        end else begin
            err_sat = pd_total[const_pack::Nerr-1:0];
        end
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            last_q      <= '0;
            err_valid_o <= 1'b0;
        end else begin
            err_valid_o <= din_valid_i;
            if (din_valid_i) begin
                last_q <= din_i[const_pack::Nti-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (din_valid_i) begin
            err_o <= err_sat;  // Only meaningful while err_valid_o is high.
        end
    end

endmodule

// ==== rtl/mm_cdr.sv ====
`timescale 1ns/1ps

module mm_cdr (
    input  logic                               clk,
    input  logic                               ext_rstb,
    input  logic signed [const_pack::Nerr-1:0] err_i,
    input  logic                               err_valid_i,
    cdr_debug_intf.loop                        dbg_i,
    output logic        [const_pack::Npi-1:0]  pi_ctl_o [const_pack::Nout-1:0],
    output logic                               freq_lvl_cross_o,
    output logic signed [const_pack::Nacc-1:0] phase_est_o,
    output logic signed [const_pack::Nacc-1:0] freq_est_o
);

    logic [cdr_pack::hold_cnt_width-1:0] hold_cnt;
    logic                                in_hold;

    logic signed [const_pack::Nerr-1:0] err_used;
    logic signed [const_pack::Nacc-1:0] err_ext;
    logic signed [const_pack::Nacc-1:0] freq_upd;
    logic signed [const_pack::Nacc-1:0] freq_d;
    logic signed [const_pack::Nacc-1:0] phase_d;
    logic signed [const_pack::Nacc-1:0] freq_q;
    logic signed [const_pack::Nacc-1:0] phase_q;
    logic signed [const_pack::Nacc-1:0] phase_scaled;
    logic        [const_pack::Npi-1:0]  pi_code;

    // ------------------------------------------------------------------------
    // Reset hold
    // ------------------------------------------------------------------------

    // The counter stops once the hold has run out and stays there until reset.
    assign in_hold = (32'(hold_cnt) < cdr_pack::reset_hold_cycles);

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            hold_cnt <= '0;
        end else if (in_hold) begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    assign err_used = in_hold ? '0 : err_i;
    assign err_ext  = err_used;  // Sign extends to the accumulator width.

    // ------------------------------------------------------------------------
    // Second-order loop filter
    // ------------------------------------------------------------------------

    always_comb begin
        freq_upd = freq_q + (err_ext <<< dbg_i.Ki);
        freq_d   = dbg_i.en_freq_est ? freq_upd : '0;
        // The integral term enters the phase with its value from before this update.
        phase_d  = phase_q + (err_ext <<< dbg_i.Kp) + freq_q;
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            phase_q          <= '0;
            freq_q           <= '0;
            freq_lvl_cross_o <= 1'b0;
        end else if (err_valid_i) begin
            phase_q          <= phase_d;
            freq_q           <= freq_d;
            freq_lvl_cross_o <= (freq_d > freq_q);
        end
    end

    assign phase_est_o = phase_q;
    assign freq_est_o  = freq_q;

    // ------------------------------------------------------------------------
    // Interpolator codes
    // ------------------------------------------------------------------------

    // Drop the fraction and the low error bits; the code wraps with the phase.
    assign phase_scaled = phase_q >>> (const_pack::phase_est_shift + const_pack::Nerr
                                       - const_pack::Npi);
    assign pi_code      = phase_scaled[const_pack::Npi-1:0];

    always_comb begin
        for (int j = 0; j < const_pack::Nout; j++) begin
            pi_ctl_o[j] = dbg_i.en_ext_pi_ctl ? dbg_i.ext_pi_ctl : pi_code;
        end
    end

endmodule

// ==== rtl/cdr_snapshot.sv ====
`timescale 1ns/1ps

module cdr_snapshot (
    input  logic                               clk,
    input  logic                               ext_rstb,
    input  logic                               sample_req_i,
    input  logic signed [const_pack::Nacc-1:0] phase_est_i,
    input  logic signed [const_pack::Nacc-1:0] freq_est_i,
    output logic signed [const_pack::Nacc-1:0] snap_phase_o,
    output logic signed [const_pack::Nacc-1:0] snap_freq_o
);

    cdr_pack::snap_state_t state_q;

    // A request must be seen low in WAIT before the block arms again, so a
    // request held high gives a single capture.
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            state_q      <= cdr_pack::WAIT;
            snap_phase_o <= '0;
            snap_freq_o  <= '0;
        end else begin
            case (state_q)
                cdr_pack::WAIT: begin
                    if (!sample_req_i) begin
                        state_q <= cdr_pack::READY;
                    end
                end
                cdr_pack::READY: begin
                    if (sample_req_i) begin
                        state_q <= cdr_pack::SAMPLE;
                    end
                end
                cdr_pack::SAMPLE: begin
                    snap_phase_o <= phase_est_i;  // Both taken on the same edge.
                    snap_freq_o  <= freq_est_i;
                    state_q      <= cdr_pack::WAIT;
                end
                default: begin
                    state_q <= cdr_pack::WAIT;
                end
            endcase
        end
    end

endmodule

// ==== rtl/cdr_top.sv ====
`timescale 1ns/1ps

module cdr_top (
    input  logic                                clk,
    input  logic                                ext_rstb,
    input  logic signed [const_pack::Nadc-1:0]  din_i [const_pack::Nti-1:0],
    input  logic                                din_valid_i,
    input  logic signed [const_pack::Nerr-1:0]  pd_offset_i,
    input  logic        [cdr_pack::gain_width-1:0] kp_i,
    input  logic        [cdr_pack::gain_width-1:0] ki_i,
    input  logic                                en_freq_est_i,
    input  logic                                en_ext_pi_ctl_i,
    input  logic        [const_pack::Npi-1:0]   ext_pi_ctl_i,
    input  logic                                sample_req_i,
    output logic        [const_pack::Npi-1:0]   pi_ctl_o [const_pack::Nout-1:0],
    output logic                                freq_lvl_cross_o,
    output logic signed [const_pack::Nacc-1:0]  snap_phase_o,
    output logic signed [const_pack::Nacc-1:0]  snap_freq_o
);

    logic signed [const_pack::Nerr-1:0] err;
    logic                               err_valid;
    logic signed [const_pack::Nacc-1:0] phase_est;
    logic signed [const_pack::Nacc-1:0] freq_est;

    cdr_debug_intf dbg ();

    // Debug fields come straight from the pins.
    assign dbg.pd_offset     = pd_offset_i;
    assign dbg.Kp            = kp_i;
    assign dbg.Ki            = ki_i;
    assign dbg.en_freq_est   = en_freq_est_i;
    assign dbg.en_ext_pi_ctl = en_ext_pi_ctl_i;
    assign dbg.ext_pi_ctl    = ext_pi_ctl_i;

    mm_pd u_pd (
        .clk         (clk),
        .ext_rstb    (ext_rstb),
        .din_i       (din_i),
        .din_valid_i (din_valid_i),
        .dbg_i       (dbg.pd),
        .err_o       (err),
        .err_valid_o (err_valid)
    );

    mm_cdr u_cdr (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .err_i            (err),
        .err_valid_i      (err_valid),
        .dbg_i            (dbg.loop),
        .pi_ctl_o         (pi_ctl_o),
        .freq_lvl_cross_o (freq_lvl_cross_o),
        .phase_est_o      (phase_est),
        .freq_est_o       (freq_est)
    );

    cdr_snapshot u_snap (
        .clk          (clk),
        .ext_rstb     (ext_rstb),
        .sample_req_i (sample_req_i),
        .phase_est_i  (phase_est),
        .freq_est_i   (freq_est),
        .snap_phase_o (snap_phase_o),
        .snap_freq_o  (snap_freq_o)
    );

endmodule

// ==== test/tb_cdr_top.sv ====
`timescale 1ns/1ps

module tb_cdr_top;

    localparam int max_cycles = 2000;  // Tests need about 250 cycles.

    logic                               clk = 1'b0;
    logic                               ext_rstb;
    logic signed [const_pack::Nadc-1:0] din [const_pack::Nti-1:0];
    logic                               din_valid;
    logic signed [const_pack::Nerr-1:0] pd_offset;
    logic [cdr_pack::gain_width-1:0]    kp;
    logic [cdr_pack::gain_width-1:0]    ki;
    logic                               en_freq_est;
    logic                               en_ext_pi_ctl;
    logic [const_pack::Npi-1:0]         ext_pi_ctl;
    logic                               sample_req;
    logic [const_pack::Npi-1:0]         pi_ctl [const_pack::Nout-1:0];
    logic                               freq_lvl_cross;
    logic signed [const_pack::Nacc-1:0] snap_phase;
    logic signed [const_pack::Nacc-1:0] snap_freq;

    // The reference model state updates on the same edges as the DUT.
    logic signed [const_pack::Nadc-1:0] m_last;
    logic signed [const_pack::Nerr-1:0] m_err;
    logic                               m_err_valid;
    logic signed [const_pack::Nacc-1:0] m_phase;
    logic signed [const_pack::Nacc-1:0] m_freq;
    logic                               m_cross;
    int                                 m_hold;
    int                                 seed = 9711;
    int                                 cycle_count = 0;

    cdr_top uut (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .din_i            (din),
        .din_valid_i      (din_valid),
        .pd_offset_i      (pd_offset),
        .kp_i             (kp),
        .ki_i             (ki),
        .en_freq_est_i    (en_freq_est),
        .en_ext_pi_ctl_i  (en_ext_pi_ctl),
        .ext_pi_ctl_i     (ext_pi_ctl),
        .sample_req_i     (sample_req),
        .pi_ctl_o         (pi_ctl),
        .freq_lvl_cross_o (freq_lvl_cross),
        .snap_phase_o     (snap_phase),
        .snap_freq_o      (snap_freq)
    );

    always #4 clk = ~clk;

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    function automatic int sgn(input int v);
        return (v >= 0) ? 1 : -1;
    endfunction

    function automatic logic signed [const_pack::Nacc-1:0] wrap_acc(input int v);
        return v[const_pack::Nacc-1:0];
    endfunction

    function automatic logic signed [const_pack::Nerr-1:0] pd_error(
        input logic signed [const_pack::Nadc-1:0] w [const_pack::Nti-1:0],
        input logic signed [const_pack::Nadc-1:0] prev_last,
        input logic signed [const_pack::Nerr-1:0] offset
    );
        int x [0:const_pack::Nti];
        int total;
        total = int'(offset);
        x[0]  = int'(prev_last);
        for (int k = 0; k < const_pack::Nti; k++) begin
            x[k+1] = int'(w[k]);
        end
        for (int k = 1; k <= const_pack::Nti; k++) begin
            total = total + sgn(x[k-1]) * x[k] - sgn(x[k]) * x[k-1];
        end
        if (total > (1 << (const_pack::Nerr - 1)) - 1) begin
            total = (1 << (const_pack::Nerr - 1)) - 1;
        end else if (total < -(1 << (const_pack::Nerr - 1))) begin
            total = -(1 << (const_pack::Nerr - 1));
        end
        return total[const_pack::Nerr-1:0];
    endfunction

    function automatic logic [const_pack::Npi-1:0] expected_pi();
        int p;
        if (en_ext_pi_ctl) begin
            return ext_pi_ctl;
        end
        p = int'(m_phase) >>> (const_pack::phase_est_shift + const_pack::Nerr - const_pack::Npi);
        return p[const_pack::Npi-1:0];
    endfunction

    always @(posedge clk or negedge ext_rstb) begin : ref_model
        int e;
        int f_next;
        int p_next;
        if (!ext_rstb) begin
            m_last      <= '0;
            m_err       <= '0;
            m_err_valid <= 1'b0;
            m_phase     <= '0;
            m_freq      <= '0;
            m_cross     <= 1'b0;
            m_hold      <= 0;
        end else begin
            if (m_hold < cdr_pack::reset_hold_cycles) begin
                m_hold <= m_hold + 1;  // Counts clocks, not words.
            end
            m_err_valid <= din_valid;
            if (din_valid) begin
                m_err  <= pd_error(din, m_last, pd_offset);
                m_last <= din[const_pack::Nti-1];
            end
            if (m_err_valid) begin
                e       = (m_hold < cdr_pack::reset_hold_cycles) ? 0 : int'(m_err);
                f_next  = en_freq_est ? int'(m_freq) + e * (1 << ki) : 0;
                p_next  = int'(m_phase) + e * (1 << kp) + int'(m_freq);
                m_freq  <= wrap_acc(f_next);
                m_phase <= wrap_acc(p_next);
                m_cross <= (wrap_acc(f_next) > m_freq);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Checks and drivers
    // ------------------------------------------------------------------------

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout after %0d cycles, the tests did not finish.", max_cycles);
            abort_run();
        end
    end

    task automatic check_pi(input string name, input logic [const_pack::Npi-1:0] got,
                            input logic [const_pack::Npi-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_acc(input string name, input logic signed [const_pack::Nacc-1:0] got,
                             input logic signed [const_pack::Nacc-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s expected %0b, got %0b", $time, name, exp, got);
            abort_run();
        end
    endtask

    // Waits for the falling edge and compares the loop outputs with the model.
    task automatic next_cycle();
        logic [const_pack::Npi-1:0] exp_code;
        @(negedge clk);
        exp_code = expected_pi();
        for (int j = 0; j < const_pack::Nout; j++) begin
            check_pi($sformatf("pi_ctl_o[%0d]", j), pi_ctl[j], exp_code);
        end
        check_bit("freq_lvl_cross_o", freq_lvl_cross, m_cross);
    endtask

    task automatic drive_random_word();
        int rnd;
        for (int k = 0; k < const_pack::Nti; k++) begin
            rnd    = $random(seed);
            din[k] = rnd[const_pack::Nadc-1:0];
        end
        din_valid = 1'b1;
    endtask

    task automatic drive_fill(input logic signed [const_pack::Nadc-1:0] fill,
                              input logic signed [const_pack::Nadc-1:0] last_lane);
        for (int k = 0; k < const_pack::Nti - 1; k++) begin
            din[k] = fill;
        end
        din[const_pack::Nti-1] = last_lane;
        din_valid              = 1'b1;
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------

    task automatic test_reset_hold();
        check_pi("pi_ctl_o[0]", pi_ctl[0], '0);
        check_pi("pi_ctl_o[1]", pi_ctl[1], '0);
        check_bit("freq_lvl_cross_o", freq_lvl_cross, 1'b0);
        check_acc("snap_phase_o", snap_phase, '0);
        check_acc("snap_freq_o", snap_freq, '0);
        kp = 3'd7;
        repeat (32) begin
            drive_random_word();
            next_cycle();
            check_pi("pi_ctl_o[0]", pi_ctl[0], '0);
        end
    endtask

    // Each word reaches pi_ctl_o two edges later, which the model pipeline mirrors.
    task automatic test_proportional();
        en_freq_est = 1'b0;
        for (int g = 0; g < 8; g += 2) begin
            kp = g[cdr_pack::gain_width-1:0];
            repeat (20) begin
                drive_random_word();
                next_cycle();
            end
        end
    endtask

    task automatic test_offset_saturation();
        kp        = 3'd3;
        pd_offset = 10'sd37;
        repeat (8) begin
            drive_fill(8'sd0, 8'sd0);
            next_cycle();
        end
        pd_offset = {1'b0, {(const_pack::Nerr - 1){1'b1}}};
        repeat (6) begin
            drive_fill(8'sd0, 8'sd127);
            next_cycle();
            drive_fill(8'sd0, 8'sd0);
            next_cycle();
        end
        pd_offset = {1'b1, {(const_pack::Nerr - 1){1'b0}}};
        repeat (6) begin
            drive_fill(8'sd0, 8'sh80);  // Most negative sample.
            next_cycle();
            drive_fill(8'sd0, 8'sd0);
            next_cycle();
        end
    endtask

    task automatic test_integral();
        kp          = 3'd1;
        ki          = 3'd2;
        en_freq_est = 1'b1;
        pd_offset   = 10'sd20;
        for (int i = 0; i < 16; i++) begin
            drive_fill(8'sd0, 8'sd0);
            next_cycle();
            if (i >= 3) check_bit("freq_lvl_cross_o", freq_lvl_cross, 1'b1);
        end
        pd_offset = -10'sd20;
        for (int i = 0; i < 16; i++) begin
            drive_fill(8'sd0, 8'sd0);
            next_cycle();
            if (i >= 3) check_bit("freq_lvl_cross_o", freq_lvl_cross, 1'b0);
        end
    endtask

    task automatic test_override();
        int rnd;
        pd_offset     = '0;
        ki            = 3'd0;
        en_ext_pi_ctl = 1'b1;
        repeat (20) begin
            rnd        = $random(seed);
            ext_pi_ctl = rnd[const_pack::Npi-1:0];
            drive_random_word();
            next_cycle();
            check_pi("pi_ctl_o[0]", pi_ctl[0], ext_pi_ctl);
            check_pi("pi_ctl_o[1]", pi_ctl[1], ext_pi_ctl);
        end
        en_ext_pi_ctl = 1'b0;
        repeat (10) begin
            drive_random_word();
            next_cycle();
        end
    endtask

    task automatic test_snapshot();
        logic signed [const_pack::Nacc-1:0] held_phase;
        logic signed [const_pack::Nacc-1:0] held_freq;
        for (int pass = 0; pass < 2; pass++) begin
            din_valid  = 1'b0;
            sample_req = 1'b0;
            repeat (3) next_cycle();  // Pipeline drains and the FSM arms.
            sample_req = 1'b1;
            repeat (2) next_cycle();
            check_acc("snap_phase_o", snap_phase, m_phase);
            check_acc("snap_freq_o", snap_freq, m_freq);
            held_phase = m_phase;
            held_freq  = m_freq;
            // The loop moves on while the request stays high.
            repeat (8) begin
                drive_random_word();
                next_cycle();
                check_acc("snap_phase_o", snap_phase, held_phase);
                check_acc("snap_freq_o", snap_freq, held_freq);
            end
        end
        din_valid  = 1'b0;
        sample_req = 1'b0;
        next_cycle();
    endtask

    initial begin
        ext_rstb = 1'b0;
        foreach (din[k]) din[k] = '0;
        din_valid     = 1'b0;
        pd_offset     = '0;
        kp            = '0;
        ki            = '0;
        en_freq_est   = 1'b0;
        en_ext_pi_ctl = 1'b0;
        ext_pi_ctl    = '0;
        sample_req    = 1'b0;
        repeat (2) @(negedge clk);
        ext_rstb = 1'b1;
        test_reset_hold();
        test_proportional();
        test_offset_saturation();
        test_integral();
        test_override();
        test_snapshot();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== sources.f ====
rtl/const_pack.sv
rtl/cdr_pack.sv
rtl/cdr_debug_intf.sv
rtl/mm_pd.sv
rtl/mm_cdr.sv
rtl/cdr_snapshot.sv
rtl/cdr_top.sv
test/tb_cdr_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the CDR testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_cdr_top \
    -Mdir obj_dir -o sim_cdr
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_cdr > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
